//--- cpuCore.f
+incdir+source
source/cpuIsaPkg.sv
source/cpuCtrlPkg.sv
source/aluUnit.sv
source/registerBank.sv
source/programCounter.sv
source/busDatapath.sv
source/controlSequencer.sv
source/cpuCore.sv
tests/cpuCore_sva.sv
tests/cpuCore_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f cpuCore.f --top-module cpuCore_tb \
	-Mdir obj_dir -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "Test completed successfully" sim.log; then
	exit 0
else
	exit 1
fi

//--- tests/cpuCore_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpuCore_tb;
	import cpuIsaPkg::*;

	// Five tests, 20 instructions, 8 accesses, 5 cycles each
	localparam int CYCLE_LIMIT = 5 * 20 * 8 * 5;
	localparam word_t TAKEN_MARK = 16'hAAAA;
	localparam word_t FALL_MARK = 16'h5555;

	logic clk;
	logic rst;
	word_t memAddr, memWData, memRData;
	logic memRead, memWrite, memReady, halted;

	word_t mem [0:1023];
	int loc;
	int delay;
	logic busy;
	int cycleCount;
	word_t wrAddr [$];
	word_t wrData [$];
	word_t expAddr [$];
	word_t expData [$];

	cpuCore i_cpuCore (
		.clk(clk), .rst(rst), .memAddr(memAddr), .memRead(memRead),
		.memWrite(memWrite), .memWData(memWData), .memRData(memRData),
		.memReady(memReady), .halted(halted)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT)
		begin
			$display("Timeout: no result after %0d cycles", cycleCount);
			$display("Test failed");
			$fatal(1);
		end
	end

	////////////////////////////////////////
	// Memory model
	////////////////////////////////////////

	always @(negedge clk)
	begin
		if (rst)
		begin
			memReady = 1'b0;
			busy = 1'b0;
		end
		else if (memReady)
			memReady = 1'b0;   // One cycle pulse
		else if (memRead || memWrite)
		begin
			if (!busy)
			begin
				busy = 1'b1;
				delay = $urandom_range(3, 0);
			end
			if (delay == 0)
			begin
				busy = 1'b0;
				memReady = 1'b1;
				if (memRead)
					memRData = mem[memAddr[10:1]];
				else
				begin
					wrAddr.push_back(memAddr);
					wrData.push_back(memWData);
					mem[memAddr[10:1]] = memWData;
				end
			end
			else
				delay = delay - 1;
		end
	end

	////////////////////////////////////////
	// Checks and program building
	////////////////////////////////////////

	task automatic compareValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("error %s: got %h, expected %h", name, actual, expected);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	function automatic word_t encode(input logic [1:0] cls, input logic [2:0] sub,
		input logic [2:0] r1, input logic [1:0] mode, input logic [2:0] r2);
		return {cls, sub, r1, mode, r2, 3'b000};
	endfunction

	task automatic emit(input word_t w);
		mem[loc] = w;
		loc = loc + 1;
	endtask

	task automatic newProgram;
		for (int i = 0; i < 1024; i++)
			mem[i] = {5'b11111, 11'(i)};   // Halt words with the index in the low bits
		loc = 0;
		expAddr.delete();
		expData.delete();
	endtask

	task automatic loadImm(input logic [2:0] r, input word_t value);
		emit(encode(2'b00, 3'b000, r, 2'b00, 3'd0));
		emit(value);
	endtask

	task automatic moveReg(input logic [2:0] rd, input logic [2:0] rs);
		emit(encode(2'b00, 3'b000, rd, 2'b01, rs));
	endtask

	task automatic storeWord(input logic [2:0] base, input logic [2:0] src, input word_t addr);
		emit(encode(2'b00, 3'b001, base, 2'b00, src));
		emit(addr);
	endtask

	task automatic aluImm(input logic [2:0] op, input logic [2:0] r, input word_t value);
		emit(encode(2'b01, op, r, 2'b00, 3'd0));
		emit(value);
	endtask

	task automatic aluReg(input logic [2:0] op, input logic [2:0] r1, input logic [2:0] r2);
		emit(encode(2'b01, op, r1, 2'b01, r2));
	endtask

	task automatic branch(input logic [2:0] cond, input logic inv, input word_t offset);
		emit(encode(2'b10, cond, {inv, 2'b00}, 2'b00, 3'd0));
		emit(offset);
	endtask

	task automatic halt;
		emit(encode(2'b11, 3'b111, 3'd0, 2'b00, 3'd0));
	endtask

	task automatic expectWrite(input word_t addr, input word_t data);
		expAddr.push_back(addr);
		expData.push_back(data);
	endtask

	task automatic runProgram;
		@(negedge clk);
		rst = 1'b1;
		wrAddr.delete();
		wrData.delete();
		repeat (2) @(negedge clk);
		rst = 1'b0;
		while (!halted)
			@(negedge clk);
		compareValue("write count", 32'(wrAddr.size()), 32'(expAddr.size()));
		for (int i = 0; i < expAddr.size(); i++)
		begin
			compareValue("memAddr", 32'(wrAddr[i]), 32'(expAddr[i]));
			compareValue("memWData", 32'(wrData[i]), 32'(expData[i]));
		end
	endtask

	// Expected r1 after an ALU op
	function automatic word_t aluRef(input logic [2:0] op, input word_t a, input word_t b);
		case (op)
			3'b000: return a + b;
			3'b001: return a - b;
			3'b011: return -a;
			3'b100: return a & b;
			3'b101: return a | b;
			default: return a;   // Compare
		endcase
	endfunction

	// Flag tested by a branch condition after one ALU op
	function automatic logic flagRef(input logic [2:0] cond, input logic [2:0] op,
		input word_t a, input word_t b);
		logic [16:0] full;
		word_t res;
		logic ovf;
		full = (op == 3'b000) ? {1'b0, a} + {1'b0, b} : {1'b0, a} - {1'b0, b};
		res = full[15:0];
		if (op == 3'b000)
			ovf = (a[15] == b[15]) && (res[15] != a[15]);
		else
			ovf = (a[15] != b[15]) && (res[15] != a[15]);
		case (cond)
			3'd0: return res == 16'h0000;
			3'd1: return full[16];   // Carry setups use add only
			3'd2: return ovf;
			3'd3: return res[15];
			default: return 1'b1;
		endcase
	endfunction

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic resetTest;
		int waitCycles;
		waitCycles = 0;
		@(negedge clk);
		compareValue("memRead", 32'(memRead), 32'd0);
		compareValue("memWrite", 32'(memWrite), 32'd0);
		compareValue("halted", 32'(halted), 32'd0);
		rst = 1'b0;
		while (!memRead)
		begin
			@(negedge clk);
			waitCycles++;
			compareValue("memWrite", 32'(memWrite), 32'd0);
			compareValue("halted", 32'(halted), 32'd0);
			if (waitCycles > 2)
			begin
				$display("First fetch did not start after reset");
				$display("Test failed");
				$fatal(1);
			end
		end
		compareValue("memAddr", 32'(memAddr), 32'(`CPU_RESET_PC));
	endtask

	task automatic moveStoreTest;
		newProgram();
		loadImm(3'd1, 16'h1234);
		moveReg(3'd2, 3'd1);
		loadImm(3'd3, 16'h0010);
		storeWord(3'd3, 3'd2, 16'h0100);
		expectWrite(16'h0110, 16'h1234);
		moveReg(3'd4, 3'd3);
		storeWord(3'd0, 3'd4, 16'h0122);
		expectWrite(16'h0122, 16'h0010);
		halt();
		runProgram();
	endtask

	task automatic aluTest;
		word_t a, b;
		logic [2:0] ops [6];
		ops = '{3'b000, 3'b001, 3'b010, 3'b011, 3'b100, 3'b101};
		newProgram();
		foreach (ops[i])
		begin
			a = 16'($urandom);
			b = 16'($urandom);
			loadImm(3'd1, a);
			loadImm(3'd2, b);
			aluReg(ops[i], 3'd1, 3'd2);
			storeWord(3'd0, 3'd1, 16'(16'h0300 + 4 * i));
			expectWrite(16'(16'h0300 + 4 * i), aluRef(ops[i], a, b));
			loadImm(3'd1, a);
			aluImm(ops[i], 3'd1, b);
			storeWord(3'd0, 3'd1, 16'(16'h0302 + 4 * i));
			expectWrite(16'(16'h0302 + 4 * i), aluRef(ops[i], a, b));
		end
		halt();
		runProgram();
	endtask

	task automatic branchTest;
		int n;
		logic flag;
		logic [2:0] op;
		word_t a, b, mark;
		n = 0;
		newProgram();
		loadImm(3'd6, TAKEN_MARK);
		loadImm(3'd7, FALL_MARK);
		for (int cond = 0; cond < 5; cond++)
		begin
			for (int state = 0; state < 2; state++)
			begin
				if (cond != 4 || state == 0)
				begin
					case ({3'(cond), 1'(state)})
						4'b0000: {op, a, b} = {3'b001, 16'h0005, 16'h0005};
						4'b0010: {op, a, b} = {3'b000, 16'hFFFF, 16'h0001};
						4'b0100: {op, a, b} = {3'b000, 16'h7FFF, 16'h0001};
						4'b0110: {op, a, b} = {3'b001, 16'h0000, 16'h0001};
						4'b0001, 4'b0111: {op, a, b} = {3'b001, 16'h0005, 16'h0003};
						default: {op, a, b} = {3'b000, 16'h0001, 16'h0001};
					endcase
					loadImm(3'd1, a);
					aluImm(op, 3'd1, b);
					flag = flagRef(3'(cond), op, a, b);
					for (int inv = 0; inv < 2; inv++)
					begin
						mark = 16'(16'h0300 + 2 * n);
						branch(3'(cond), 1'(inv), 16'd10);   // Target is the second store
						storeWord(3'd0, 3'd7, mark);
						branch(3'd4, 1'b0, 16'd6);
						storeWord(3'd0, 3'd6, mark);
						expectWrite(mark, (flag ^ 1'(inv)) ? TAKEN_MARK : FALL_MARK);
						n++;
					end
				end
			end
		end
		halt();
		runProgram();
	endtask

	task automatic haltTest;
		newProgram();
		loadImm(3'd1, 16'h00FF);
		halt();
		runProgram();
		repeat (50)
		begin
			@(negedge clk);
			compareValue("memRead", 32'(memRead), 32'd0);
			compareValue("halted", 32'(halted), 32'd1);
		end
	endtask

	initial
	begin
		rst = 1'b1;
		memRData = '0;
		memReady = 1'b0;
		busy = 1'b0;
		delay = 0;
		cycleCount = 0;
		void'($urandom(77));
		newProgram();
		repeat (1) @(negedge clk);
		resetTest();
		moveStoreTest();
		aluTest();
		branchTest();
		haltTest();
		if (i_cpuCore.i_cpuCore_sva.failCount == 0)
		begin
			$display("Test completed successfully");
			$finish;
		end
		else
		begin
			$display("Memory port assertions failed %0d times",
				i_cpuCore.i_cpuCore_sva.failCount);
			$display("Test failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

//--- tests/cpuCore_sva.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore_sva (
	input  logic clk,
	input  logic rst,
	input  cpuIsaPkg::word_t memAddr,
	input  logic memRead,
	input  logic memWrite,
	input  logic memReady,
	input  logic halted
);

	int failCount = 0;

	// One kind of request at a time
	noReadWriteOverlap: assert property (
		@(posedge clk) disable iff (rst) !(memRead && memWrite)
	) else
	begin
		failCount++;
		$error("memRead and memWrite high together");
	end

	// Address held while the memory has not answered
	addrStableWhileWaiting: assert property (
		@(posedge clk) disable iff (rst)
		(memRead || memWrite) && !memReady |=> $stable(memAddr)
	) else
	begin
		failCount++;
		$error("memAddr changed during a pending request");
	end

	haltedSticky: assert property (
		@(posedge clk) disable iff (rst) halted |=> halted
	) else
	begin
		failCount++;
		$error("halted dropped without reset");
	end

endmodule

bind cpuCore cpuCore_sva i_cpuCore_sva (
	.clk(clk),
	.rst(rst),
	.memAddr(memAddr),
	.memRead(memRead),
	.memWrite(memWrite),
	.memReady(memReady),
	.halted(halted)
);

`default_nettype wire

//--- source/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpuCore (
	input  logic clk,
	input  logic rst,
	output cpuIsaPkg::word_t memAddr,
	output logic memRead,
	output logic memWrite,
	output cpuIsaPkg::word_t memWData,
	input  cpuIsaPkg::word_t memRData,
	input  logic memReady,
	output logic halted
);
	import cpuIsaPkg::*;
	import cpuCtrlPkg::*;

	busSrc_t busSrc;
	logic ldMar, ldMdr, ldIr, ldY, ldSave, ldPc, branchTaken;
	regIdx_t regSel;
	logic regWrite;
	aluOp_t aluOp;
	word_t instr, busOut, yValue, regData, pc, aluResult;
	logic zero, carry, overflow, sign;

	controlSequencer i_controlSequencer (
		.clk(clk), .rst(rst), .instr(instr),
		.zero(zero), .carry(carry), .overflow(overflow), .sign(sign),
		.memReady(memReady), .busSrc(busSrc),
		.ldMar(ldMar), .ldMdr(ldMdr), .ldIr(ldIr), .ldY(ldY),
		.ldSave(ldSave), .ldPc(ldPc), .branchTaken(branchTaken),
		.regSel(regSel), .regWrite(regWrite), .aluOp(aluOp),
		.memRead(memRead), .memWrite(memWrite), .halted(halted)
	);

	busDatapath i_busDatapath (
		.clk(clk), .rst(rst), .busSrc(busSrc),
		.ldMar(ldMar), .ldMdr(ldMdr), .ldIr(ldIr), .ldY(ldY), .ldSave(ldSave),
		.memRData(memRData), .regData(regData), .pc(pc), .aluResult(aluResult),
		.instr(instr), .busOut(busOut), .yValue(yValue),
		.memAddr(memAddr), .memWData(memWData)
	);

	registerBank i_registerBank (
		.clk(clk), .rst(rst), .regSel(regSel), .regWrite(regWrite),
		.writeData(busOut), .readData(regData)
	);

	// ALU takes r1 from the bus and the operand from Y
	aluUnit i_aluUnit (
		.clk(clk), .rst(rst), .x(busOut), .y(yValue), .aluOp(aluOp),
		.ldSave(ldSave), .result(aluResult),
		.zero(zero), .carry(carry), .overflow(overflow), .sign(sign)
	);

	programCounter i_programCounter (
		.clk(clk), .rst(rst), .ldPc(ldPc), .branchTaken(branchTaken),
		.offset(memWData), .pc(pc)   // Branch offset sits in MDR
	);

endmodule

`default_nettype wire

//--- source/controlSequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module controlSequencer (
	input  logic clk,
	input  logic rst,
	input  cpuIsaPkg::word_t instr,
	input  logic zero,
	input  logic carry,
	input  logic overflow,
	input  logic sign,
	input  logic memReady,
	output cpuCtrlPkg::busSrc_t busSrc,
	output logic ldMar,
	output logic ldMdr,
	output logic ldIr,
	output logic ldY,
	output logic ldSave,
	output logic ldPc,
	output logic branchTaken,
	output cpuIsaPkg::regIdx_t regSel,
	output logic regWrite,
	output cpuIsaPkg::aluOp_t aluOp,
	output logic memRead,
	output logic memWrite,
	output logic halted
);
	import cpuIsaPkg::*;
	import cpuCtrlPkg::*;

	seqState_t state, nextState;
	instrClass_t iClass;
	logic [2:0] subOp;
	logic [1:0] mode;
	regIdx_t r1, r2;
	logic isLoadImm, isMove, isStore, isAluImm, isAluReg, isBranch, isHalt;
	logic condFlag, condMet;

	////////////////////////////////////////
	// Decode
	////////////////////////////////////////

	assign iClass = instrClass_t'(instr[CLASS_LSB +: 2]);
	assign subOp = instr[SUB_LSB +: 3];
	assign mode = instr[MODE_LSB +: 2];
	assign r1 = instr[R1_LSB +: 3];
	assign r2 = instr[R2_LSB +: 3];

	assign isLoadImm = (iClass == CLS_LDST) && (subOp == SUB_MOVE) && (mode == MODE_IMM);
	assign isMove = (iClass == CLS_LDST) && (subOp == SUB_MOVE) && (mode == MODE_REG);
	assign isStore = (iClass == CLS_LDST) && (subOp == SUB_STORE) && (mode == MODE_IMM);
	assign isAluImm = (iClass == CLS_ALU) && (mode == MODE_IMM);
	assign isAluReg = (iClass == CLS_ALU) && (mode == MODE_REG);
	assign isBranch = (iClass == CLS_BRANCH);
	assign isHalt = (iClass == CLS_CTRL) && (subOp == SUB_HALT);

	always_comb
	begin
		case (cond_t'(subOp))
			COND_ZERO: condFlag = zero;
			COND_CARRY: condFlag = carry;
			COND_OVERFLOW: condFlag = overflow;
			COND_SIGN: condFlag = sign;
			COND_ALWAYS: condFlag = 1'b1;
			default: condFlag = 1'b0;
		endcase
	end

	assign condMet = condFlag ^ instr[INV_BIT];

	////////////////////////////////////////
	// State machine
	////////////////////////////////////////

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			state <= S_IDLE;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		busSrc = BUS_NONE;   // MDR takes memory data
		ldMar = 1'b0;
		ldMdr = 1'b0;
		ldIr = 1'b0;
		ldY = 1'b0;
		ldSave = 1'b0;
		ldPc = 1'b0;
		branchTaken = 1'b0;
		regSel = r1;
		regWrite = 1'b0;
		aluOp = ALU_ADD;
		memRead = 1'b0;
		memWrite = 1'b0;
		halted = 1'b0;
		case (state)
			S_IDLE: nextState = S_FETCH;
			S_FETCH:
			begin
				busSrc = BUS_PC;
				ldMar = 1'b1;
				nextState = S_IWAIT;
			end
			S_IWAIT:
			begin
				memRead = 1'b1;
				if (memReady)
				begin
					ldIr = 1'b1;
					ldPc = 1'b1;
					nextState = S_DECODE;
				end
			end
			S_DECODE:
			begin
				if (isLoadImm || isStore || isAluImm || isBranch)
					nextState = S_OPFETCH;
				else if (isMove)
					nextState = S_MOVE;
				else if (isAluReg)
					nextState = S_REGY;
				else if (isHalt)
					nextState = S_HALT;
				else
					nextState = S_FETCH;   // Unused encodings do nothing
			end
			S_OPFETCH:
			begin
				busSrc = BUS_PC;
				ldMar = 1'b1;
				nextState = S_OPWAIT;
			end
			S_OPWAIT:
			begin
				memRead = 1'b1;
				if (memReady)
				begin
					ldMdr = 1'b1;
					ldPc = !isBranch;   // Branch steps in S_BRANCH
					if (isBranch)
						nextState = S_BRANCH;
					else if (isLoadImm)
						nextState = S_REGWR;
					else
						nextState = S_LDY;
				end
			end
			S_MOVE:
			begin
				busSrc = BUS_REG;
				regSel = r2;
				ldMdr = 1'b1;
				nextState = S_REGWR;
			end
			S_REGWR:
			begin
				busSrc = BUS_MDR;
				regWrite = 1'b1;
				nextState = S_FETCH;
			end
			S_REGY:
			begin
				busSrc = BUS_REG;
				regSel = r2;
				ldY = 1'b1;
				nextState = S_EXEC;
			end
			S_LDY:
			begin
				busSrc = BUS_MDR;
				ldY = 1'b1;
				nextState = isStore ? S_ADDR : S_EXEC;
			end
			S_EXEC:
			begin
				busSrc = BUS_REG;
				aluOp = aluOp_t'(subOp);
				ldSave = 1'b1;
				// Compare keeps r1
				nextState = (aluOp_t'(subOp) == ALU_CMP) ? S_FETCH : S_WB;
			end
			S_WB:
			begin
				busSrc = BUS_SAVE;
				regWrite = 1'b1;
				nextState = S_FETCH;
			end
			S_ADDR:
			begin
				busSrc = BUS_REG;   // Save <= Y + r1
				aluOp = ALU_ADDR;
				ldSave = 1'b1;
				nextState = S_MAR;
			end
			S_MAR:
			begin
				busSrc = BUS_SAVE;
				ldMar = 1'b1;
				nextState = S_STDATA;
			end
			S_STDATA:
			begin
				busSrc = BUS_REG;
				regSel = r2;
				ldMdr = 1'b1;
				nextState = S_STWAIT;
			end
			S_STWAIT:
			begin
				memWrite = 1'b1;
				if (memReady)
					nextState = S_FETCH;
			end
			S_BRANCH:
			begin
				ldPc = 1'b1;
				branchTaken = condMet;
				nextState = S_FETCH;
			end
			S_HALT: halted = 1'b1;   // Parked until reset
			default: nextState = S_IDLE;
		endcase
	end

endmodule

`default_nettype wire

//--- source/busDatapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module busDatapath (
	input  logic clk,
	input  logic rst,
	input  cpuCtrlPkg::busSrc_t busSrc,
	input  logic ldMar,
	input  logic ldMdr,
	input  logic ldIr,
	input  logic ldY,
	input  logic ldSave,
	input  cpuIsaPkg::word_t memRData,
	input  cpuIsaPkg::word_t regData,
	input  cpuIsaPkg::word_t pc,
	input  cpuIsaPkg::word_t aluResult,
	output cpuIsaPkg::word_t instr,
	output cpuIsaPkg::word_t busOut,
	output cpuIsaPkg::word_t yValue,
	output cpuIsaPkg::word_t memAddr,
	output cpuIsaPkg::word_t memWData
);
	import cpuIsaPkg::*;
	import cpuCtrlPkg::*;

	word_t mar, ir, mdr, y, save;
	word_t mdrIn;

	always_comb
	begin
		case (busSrc)
			BUS_PC: busOut = pc;
			BUS_MDR: busOut = mdr;
			BUS_SAVE: busOut = save;
			BUS_REG: busOut = regData;
			default: busOut = '0;
		endcase
	end

	// Idle bus means a memory read is landing
	assign mdrIn = (busSrc == BUS_NONE) ? memRData : busOut;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			mar <= '0;
			ir <= '0;
		end
		else
		begin
			if (ldMar)
				mar <= busOut;
			if (ldIr)
				ir <= memRData;
		end
	end

	always_ff @(posedge clk)
	begin
		if (ldMdr)
			mdr <= mdrIn;
		if (ldY)
			y <= busOut;
		if (ldSave)
			save <= aluResult;
	end

	assign instr = ir;
	assign yValue = y;
	assign memAddr = mar;
	assign memWData = mdr;

endmodule

`default_nettype wire

//--- source/programCounter.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module programCounter (
	input  logic clk,
	input  logic rst,
	input  logic ldPc,
	input  logic branchTaken,
	input  cpuIsaPkg::word_t offset,
	output cpuIsaPkg::word_t pc
);
	import cpuIsaPkg::*;

	word_t nextPc;

	// Offset is relative to the address of the offset word
	assign nextPc = branchTaken ? pc + offset : pc + word_t'(`CPU_PC_STEP);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			pc <= word_t'(`CPU_RESET_PC);
		else if (ldPc)
			pc <= nextPc;
	end

endmodule

`default_nettype wire

//--- source/registerBank.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module registerBank (
	input  logic clk,
	input  logic rst,
	input  cpuIsaPkg::regIdx_t regSel,
	input  logic regWrite,
	input  cpuIsaPkg::word_t writeData,
	output cpuIsaPkg::word_t readData
);
	import cpuIsaPkg::*;

	word_t regs [`CPU_REG_COUNT];

	assign readData = regs[regSel];   // Async read

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < `CPU_REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (regWrite)
		begin
			regs[regSel] <= writeData;
		end
	end

endmodule

`default_nettype wire

//--- source/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module aluUnit (
	input  logic clk,
	input  logic rst,
	input  cpuIsaPkg::word_t x,
	input  cpuIsaPkg::word_t y,
	input  cpuIsaPkg::aluOp_t aluOp,
	input  logic ldSave,
	output cpuIsaPkg::word_t result,
	output logic zero,
	output logic carry,
	output logic overflow,
	output logic sign
);
	import cpuIsaPkg::*;

	localparam int MSB = `CPU_WORD_WIDTH - 1;

	logic [`CPU_WORD_WIDTH:0] sum;
	word_t diff;
	logic addOvf, subOvf;

	assign sum = {1'b0, x} + {1'b0, y};
	assign diff = x - y;

	// Signed overflow, operands agree in sign and the result does not
	assign addOvf = (x[MSB] == y[MSB]) && (sum[MSB] != x[MSB]);
	assign subOvf = (x[MSB] != y[MSB]) && (diff[MSB] != x[MSB]);

	always_comb
	begin
		case (aluOp)
			ALU_ADD, ALU_ADDR: result = sum[MSB:0];
			ALU_SUB, ALU_CMP: result = diff;
			ALU_NEG: result = -x;
			ALU_AND: result = x & y;
			ALU_OR: result = x | y;
			default: result = '0;
		endcase
	end

	////////////////////////////////////////
	// Flags
	////////////////////////////////////////

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			zero <= 1'b0;
			carry <= 1'b0;
			overflow <= 1'b0;
			sign <= 1'b0;
		end
		else if (ldSave && aluOp != ALU_ADDR)
		begin
			zero <= (result == '0);
			sign <= result[MSB];
			if (aluOp == ALU_ADD)
			begin
				carry <= sum[`CPU_WORD_WIDTH];
				overflow <= addOvf;
			end
			else if (aluOp == ALU_SUB || aluOp == ALU_CMP)
				overflow <= subOvf;   // Carry kept
		end
	end

endmodule

`default_nettype wire

//--- source/cpuCtrlPkg.sv
`default_nettype none

package cpuCtrlPkg;

	// Driver of the internal bus
	typedef enum logic [2:0] {
		BUS_NONE, BUS_PC, BUS_MDR, BUS_SAVE, BUS_REG, BUS_ZERO
	} busSrc_t;

	typedef enum logic [4:0] {
		S_IDLE, S_FETCH, S_IWAIT, S_DECODE,
		S_OPFETCH, S_OPWAIT,
		S_MOVE, S_REGWR,
		S_REGY, S_LDY, S_EXEC, S_WB,
		S_ADDR, S_MAR, S_STDATA, S_STWAIT,
		S_BRANCH, S_HALT
	} seqState_t;

endpackage

`default_nettype wire

//--- source/cpuIsaPkg.sv
`default_nettype none

`include "cpu_config.svh"

package cpuIsaPkg;

	typedef logic [`CPU_WORD_WIDTH-1:0] word_t;
	typedef logic [2:0] regIdx_t;

	typedef enum logic [1:0] {
		CLS_LDST = 2'b00, CLS_ALU = 2'b01, CLS_BRANCH = 2'b10, CLS_CTRL = 2'b11
	} instrClass_t;

	typedef enum logic [2:0] {
		ALU_ADD = 3'b000, ALU_SUB = 3'b001, ALU_CMP = 3'b010, ALU_NEG = 3'b011,
		ALU_AND = 3'b100, ALU_OR = 3'b101,
		ALU_ADDR = 3'b110   // Internal address add, flags untouched
	} aluOp_t;

	typedef enum logic [2:0] {
		COND_ZERO = 3'b000, COND_CARRY = 3'b001, COND_OVERFLOW = 3'b010,
		COND_SIGN = 3'b011, COND_ALWAYS = 3'b100
	} cond_t;

	// Instruction fields
	localparam int CLASS_LSB = 14;
	localparam int SUB_LSB = 11;
	localparam int INV_BIT = 10;   // Branch condition inversion
	localparam int R1_LSB = 8;
	localparam int MODE_LSB = 6;
	localparam int R2_LSB = 3;

	localparam logic [2:0] SUB_MOVE = 3'b000;
	localparam logic [2:0] SUB_STORE = 3'b001;
	localparam logic [2:0] SUB_HALT = 3'b111;
	localparam logic [1:0] MODE_IMM = 2'b00;
	localparam logic [1:0] MODE_REG = 2'b01;

endpackage

`default_nettype wire

//--- source/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

////////////////////////////////////////
// Core sizing
////////////////////////////////////////

// Data and address width
`define CPU_WORD_WIDTH 16

// General purpose registers
`define CPU_REG_COUNT 8

////////////////////////////////////////
// Program counter
////////////////////////////////////////

`define CPU_PC_STEP 2     // Bytes per instruction word
`define CPU_RESET_PC 0    // First fetch address

`endif
